/* hdl/rvIsaPkg.sv */
package rvIsaPkg;

  localparam int unsigned INSTR_BYTES = 4; // Fixed 32-bit encodings, no compressed set

  // Major opcode field, instr[6:0]
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    I_OP   = 7'b0010011, // Register-immediate ALU
    R_OP   = 7'b0110011, // Register-register ALU
    FENCE  = 7'b0001111
  } opcode_t;

  // ADD must stay zero so a cleared bundle is an add
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    SLL  = 4'd2,
    SLT  = 4'd3,
    SLTU = 4'd4,
    XOR  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    OR   = 4'd8,
    AND  = 4'd9
  } aluOp_t;

  // Straight from funct3 of a conditional branch
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  typedef enum logic [2:0] {
    I_TYPE,
    S_TYPE,
    B_TYPE,
    U_TYPE,
    J_TYPE
  } immType_t;

endpackage

/* hdl/corePipePkg.sv */
package corePipePkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;   // Data, address and PC
  typedef logic [4:0]      regAddr_t;
  typedef logic [1:0]      fwdSel_t;  // Q102H operand source

  localparam word_t RESET_PC  = '0;
  localparam word_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

  // Operand source codes
  localparam fwdSel_t FWD_NONE  = 2'd0;
  localparam fwdSel_t FWD_Q103H = 2'd1; // ALU result one stage ahead
  localparam fwdSel_t FWD_Q104H = 2'd2; // Write-back data two stages ahead

  // Decoded controls leaving Q101H
  typedef struct packed {
    rvIsaPkg::aluOp_t  aluOp;
    rvIsaPkg::branch_t branch;
    logic              isBranch;
    logic              isJump;     // JAL or JALR
    logic              selAluPc;   // PC as first operand
    logic              selAluImm;  // Immediate as second operand
    logic              isLui;
    logic              regWrEn;    // Never set for x0
    logic              dMemWrEn;
    logic              selDMemWb;  // Load data to register
    logic              selRegWrPc; // Link value to register
  } ctrlBundle_t;

endpackage

/* hdl/fwdIf.sv */
`timescale 1ns/1ps

interface fwdIf
  import corePipePkg::*;
();

  regAddr_t regSrc1Q102H, regSrc2Q102H;
  regAddr_t regDstQ103H;
  logic     regWrEnQ103H;
  regAddr_t regDstQ104H;
  logic     regWrEnQ104H;
  word_t    regWrDataQ104H; // Also the register file write port
  fwdSel_t  fwdSel1Q102H, fwdSel2Q102H;

  // Controller only compares
  modport ctrl (input regSrc1Q102H, regSrc2Q102H, regDstQ103H, regWrEnQ103H,
                input regDstQ104H, regWrEnQ104H, output fwdSel1Q102H, fwdSel2Q102H);
  modport exec (output regSrc1Q102H, regSrc2Q102H, regDstQ103H, regWrEnQ103H,
                input fwdSel1Q102H, fwdSel2Q102H, regWrDataQ104H);
  modport wb   (input regDstQ103H, regWrEnQ103H,
                output regDstQ104H, regWrEnQ104H, regWrDataQ104H);

endinterface

/* hdl/pipeControl.sv */
`timescale 1ns/1ps

module pipeControl
  import rvIsaPkg::*;
  import corePipePkg::*;
(
  input  logic        Clock,
  input  logic        rst,
  input  word_t       instrRaw,          // Straight from instruction memory
  input  logic        redirect,          // Taken branch or jump in Q102H
  input  logic        opcodeIsLoadQ102H,
  input  regAddr_t    regDstQ102H,
  fwdIf.ctrl          fwd,
  output logic        pcEn,
  output word_t       instrQ101H,
  output word_t       immQ101H,
  output ctrlBundle_t ctrlQ101H
);

  logic       loadHazardQ101H, loadHazardQ102H;
  logic       flushQ103H;      // Second slot behind a redirect
  logic       fetchValid;      // Memory word not yet from the reset PC
  word_t      heldInstr;
  opcode_t    opcodeQ101H;
  logic [2:0] funct3Q101H;
  aluOp_t     arithOpQ101H;
  immType_t   immTypeQ101H;

  //////////////////// Hazards

  // Raw fields, the load result is one cycle short
  assign loadHazardQ101H = opcodeIsLoadQ102H &&
                           ((instrRaw[19:15] == regDstQ102H) || (instrRaw[24:20] == regDstQ102H));
  assign pcEn = !loadHazardQ101H;

  always_ff @(posedge Clock) begin
    if (rst) begin
      loadHazardQ102H <= 1'b0;
      flushQ103H      <= 1'b0;
      fetchValid      <= 1'b0;
    end else begin
      loadHazardQ102H <= loadHazardQ101H;
      flushQ103H      <= redirect;
      fetchValid      <= 1'b1;
    end
  end

  // Memory has moved past the stalled word, keep a copy for the replay
  always_ff @(posedge Clock) begin
    heldInstr <= instrRaw;
  end

  always_comb begin
    if (!fetchValid || redirect || flushQ103H || loadHazardQ101H) begin
      instrQ101H = NOP_INSTR; // Bubble or flushed slot
    end else if (loadHazardQ102H) begin
      instrQ101H = heldInstr;
    end else begin
      instrQ101H = instrRaw;
    end
  end

  //////////////////// Decode
  assign opcodeQ101H = opcode_t'(instrQ101H[6:0]);
  assign funct3Q101H = instrQ101H[14:12];

  always_comb begin
    case (funct3Q101H)
      3'b000:  arithOpQ101H = (opcodeQ101H == R_OP && instrQ101H[30]) ? SUB : ADD;
      3'b001:  arithOpQ101H = SLL;
      3'b010:  arithOpQ101H = SLT;
      3'b011:  arithOpQ101H = SLTU;
      3'b100:  arithOpQ101H = XOR;
      3'b101:  arithOpQ101H = instrQ101H[30] ? SRA : SRL; // Same bit for SRAI
      3'b110:  arithOpQ101H = OR;
      default: arithOpQ101H = AND;
    endcase
  end

  always_comb begin
    ctrlQ101H.aluOp      = (opcodeQ101H inside {I_OP, R_OP}) ? arithOpQ101H : ADD;
    ctrlQ101H.branch     = branch_t'(funct3Q101H);
    ctrlQ101H.isBranch   = (opcodeQ101H == BRANCH);
    ctrlQ101H.isJump     = (opcodeQ101H inside {JAL, JALR});
    ctrlQ101H.selAluPc   = (opcodeQ101H inside {AUIPC, JAL, BRANCH}); // PC-relative
    ctrlQ101H.selAluImm  = (opcodeQ101H != R_OP);
    ctrlQ101H.isLui      = (opcodeQ101H == LUI);
    // No write for x0, so the no-op leaves the forward compares idle
    ctrlQ101H.regWrEn    = (opcodeQ101H inside {LUI, AUIPC, JAL, JALR, LOAD, I_OP, R_OP}) &&
                           (instrQ101H[11:7] != '0);
    ctrlQ101H.dMemWrEn   = (opcodeQ101H == STORE);
    ctrlQ101H.selDMemWb  = (opcodeQ101H == LOAD);
    ctrlQ101H.selRegWrPc = (opcodeQ101H inside {JAL, JALR}); // Link is PC plus 4
  end

  // Immediate generator
  always_comb begin
    case (opcodeQ101H)
      LUI, AUIPC:              immTypeQ101H = U_TYPE;
      JAL:                     immTypeQ101H = J_TYPE;
      BRANCH:                  immTypeQ101H = B_TYPE;
      STORE:                   immTypeQ101H = S_TYPE;
      JALR, LOAD, I_OP, FENCE: immTypeQ101H = I_TYPE; // FENCE runs as a no-op
      default:                 immTypeQ101H = I_TYPE;
    endcase
    case (immTypeQ101H)
      S_TYPE:  immQ101H = {{20{instrQ101H[31]}}, instrQ101H[31:25], instrQ101H[11:7]};
      B_TYPE:  immQ101H = {{20{instrQ101H[31]}}, instrQ101H[7], instrQ101H[30:25],
                           instrQ101H[11:8], 1'b0};
      U_TYPE:  immQ101H = {instrQ101H[31:12], 12'b0};
      J_TYPE:  immQ101H = {{12{instrQ101H[31]}}, instrQ101H[19:12], instrQ101H[20],
                           instrQ101H[30:21], 1'b0};
      default: immQ101H = {{20{instrQ101H[31]}}, instrQ101H[31:20]};
    endcase
  end

  //////////////////// Forwarding
  function automatic fwdSel_t pickFwd(regAddr_t src);
    fwdSel_t sel;
    sel = FWD_NONE;
    if (src != '0 && fwd.regWrEnQ104H && src == fwd.regDstQ104H) sel = FWD_Q104H;
    if (src != '0 && fwd.regWrEnQ103H && src == fwd.regDstQ103H) sel = FWD_Q103H; // Newest wins
    return sel;
  endfunction

  assign fwd.fwdSel1Q102H = pickFwd(fwd.regSrc1Q102H);
  assign fwd.fwdSel2Q102H = pickFwd(fwd.regSrc2Q102H);

  // Flushed slot in Q102H cannot be a load, so no stall overlaps it
  assert property (@(posedge Clock) disable iff (rst) flushQ103H |-> (pcEn || redirect));

endmodule

/* hdl/pcFetch.sv */
`timescale 1ns/1ps

module pcFetch
  import rvIsaPkg::*;
  import corePipePkg::*;
(
  input  logic  Clock,
  input  logic  rst,
  input  logic  pcEn,     // Low during a load-use bubble
  input  logic  redirect,
  input  word_t target,   // ALU result of the Q102H branch or jump
  output word_t pcQ100H,
  output word_t pcQ101H,
  output word_t pcPlus4Q101H
);

  word_t pcPlus4Q100H;

  assign pcPlus4Q100H = pcQ100H + INSTR_BYTES;

  always_ff @(posedge Clock) begin
    if (rst) begin
      pcQ100H <= RESET_PC;
    end else if (redirect) begin
      pcQ100H <= {target[XLEN-1:1], 1'b0}; // JALR drops bit 0
    end else if (pcEn) begin
      pcQ100H <= pcPlus4Q100H;
    end
  end

  // Follows the instruction word into decode
  always_ff @(posedge Clock) begin
    if (pcEn) begin
      pcQ101H      <= pcQ100H;
      pcPlus4Q101H <= pcPlus4Q100H;
    end
  end

  assert property (@(posedge Clock) disable iff (rst) pcQ100H[1:0] == 2'b00);

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ps

module regFile
  import corePipePkg::*;
(
  input  logic     Clock,
  input  logic     rst,
  input  regAddr_t rdAddr1,
  input  regAddr_t rdAddr2,
  output word_t    rdData1,
  output word_t    rdData2,
  fwdIf.wb         fwd     // Q104H write port
);

  word_t regs [31:1]; // x0 has no storage

  always_ff @(posedge Clock) begin
    if (fwd.regWrEnQ104H && fwd.regDstQ104H != '0) begin
      regs[fwd.regDstQ104H] <= fwd.regWrDataQ104H;
    end
  end

  // Same-cycle write shows through to the reader
  function automatic word_t readPort(regAddr_t addr);
    if (addr == '0) return '0;
    if (fwd.regWrEnQ104H && addr == fwd.regDstQ104H) return fwd.regWrDataQ104H;
    return regs[addr];
  endfunction

  assign rdData1 = readPort(rdAddr1);
  assign rdData2 = readPort(rdAddr2);

  // Decoder drops the enable for x0 destinations
  assert property (@(posedge Clock) disable iff (rst)
    fwd.regWrEnQ104H |-> fwd.regDstQ104H != '0);

endmodule

/* hdl/execUnit.sv */
`timescale 1ns/1ps

module execUnit
  import rvIsaPkg::*;
  import corePipePkg::*;
(
  input  logic        Clock,
  input  logic        rst,
  input  word_t       pcQ101H,
  input  word_t       pcPlus4Q101H,
  input  word_t       instrQ101H,
  input  word_t       immQ101H,
  input  ctrlBundle_t ctrlQ101H,
  input  word_t       rdData1,
  input  word_t       rdData2,
  fwdIf.exec          fwd,
  output logic        redirect,          // Flush and load the target
  output word_t       aluOutQ102H,
  output logic        opcodeIsLoadQ102H,
  output regAddr_t    regDstQ102H,
  output word_t       aluOutQ103H,
  output word_t       storeDataQ103H,
  output word_t       pcPlus4Q103H,
  output logic        dMemWrEnQ103H,
  output logic        selDMemWbQ103H,
  output logic        selRegWrPcQ103H
);

  ctrlBundle_t ctrlQ102H;
  word_t       pcQ102H, pcPlus4Q102H, immQ102H;
  word_t       rdData1Q102H, rdData2Q102H;
  word_t       src1Q102H, src2Q102H;       // After forwarding
  word_t       aluIn1Q102H, aluIn2Q102H;
  logic [4:0]  shamtQ102H;
  logic        branchMetQ102H;

  //////////////////// Q101H to Q102H
  always_ff @(posedge Clock) begin
    if (rst) begin
      ctrlQ102H         <= '0;
      regDstQ102H       <= '0;
      fwd.regSrc1Q102H  <= '0;
      fwd.regSrc2Q102H  <= '0;
      opcodeIsLoadQ102H <= 1'b0;
    end else begin
      ctrlQ102H         <= ctrlQ101H;
      regDstQ102H       <= instrQ101H[11:7];
      fwd.regSrc1Q102H  <= instrQ101H[19:15];
      fwd.regSrc2Q102H  <= instrQ101H[24:20];
      opcodeIsLoadQ102H <= (opcode_t'(instrQ101H[6:0]) == LOAD); // For the stall check
    end
  end

  always_ff @(posedge Clock) begin
    pcQ102H      <= pcQ101H;
    pcPlus4Q102H <= pcPlus4Q101H;
    immQ102H     <= immQ101H;
    rdData1Q102H <= rdData1;
    rdData2Q102H <= rdData2;
  end

  function automatic word_t fwdMux(fwdSel_t sel, word_t regVal);
    case (sel)
      FWD_Q103H: return aluOutQ103H;
      FWD_Q104H: return fwd.regWrDataQ104H;
      default:   return regVal;
    endcase
  endfunction

  assign src1Q102H   = fwdMux(fwd.fwdSel1Q102H, rdData1Q102H);
  assign src2Q102H   = fwdMux(fwd.fwdSel2Q102H, rdData2Q102H);
  assign aluIn1Q102H = ctrlQ102H.selAluPc ? pcQ102H : src1Q102H;
  assign aluIn2Q102H = ctrlQ102H.selAluImm ? immQ102H : src2Q102H;

  //////////////////// ALU
  always_comb begin
    shamtQ102H = aluIn2Q102H[4:0];
    case (ctrlQ102H.aluOp)
      SUB:     aluOutQ102H = aluIn1Q102H - aluIn2Q102H;
      SLT:     aluOutQ102H = {31'b0, $signed(aluIn1Q102H) < $signed(aluIn2Q102H)};
      SLTU:    aluOutQ102H = {31'b0, aluIn1Q102H < aluIn2Q102H};
      SLL:     aluOutQ102H = aluIn1Q102H << shamtQ102H;
      SRL:     aluOutQ102H = aluIn1Q102H >> shamtQ102H;
      SRA:     aluOutQ102H = $signed(aluIn1Q102H) >>> shamtQ102H;
      XOR:     aluOutQ102H = aluIn1Q102H ^ aluIn2Q102H;
      OR:      aluOutQ102H = aluIn1Q102H | aluIn2Q102H;
      AND:     aluOutQ102H = aluIn1Q102H & aluIn2Q102H;
      default: aluOutQ102H = aluIn1Q102H + aluIn2Q102H; // Also addresses and targets
    endcase
    if (ctrlQ102H.isLui) aluOutQ102H = aluIn2Q102H; // Upper immediate as is
  end

  // Branch compare on forwarded sources, never on ALU inputs
  always_comb begin
    case (ctrlQ102H.branch)
      BEQ:     branchMetQ102H = (src1Q102H == src2Q102H);
      BNE:     branchMetQ102H = (src1Q102H != src2Q102H);
      BLT:     branchMetQ102H = ($signed(src1Q102H) < $signed(src2Q102H));
      BGE:     branchMetQ102H = ($signed(src1Q102H) >= $signed(src2Q102H));
      BLTU:    branchMetQ102H = (src1Q102H < src2Q102H);
      BGEU:    branchMetQ102H = (src1Q102H >= src2Q102H);
      default: branchMetQ102H = 1'b0;
    endcase
  end

  assign redirect = (ctrlQ102H.isBranch && branchMetQ102H) || ctrlQ102H.isJump;

  //////////////////// Q102H to Q103H
  always_ff @(posedge Clock) begin
    if (rst) begin
      dMemWrEnQ103H    <= 1'b0;
      selDMemWbQ103H   <= 1'b0;
      selRegWrPcQ103H  <= 1'b0;
      fwd.regDstQ103H  <= '0;
      fwd.regWrEnQ103H <= 1'b0;
    end else begin
      dMemWrEnQ103H    <= ctrlQ102H.dMemWrEn;
      selDMemWbQ103H   <= ctrlQ102H.selDMemWb;
      selRegWrPcQ103H  <= ctrlQ102H.selRegWrPc;
      fwd.regDstQ103H  <= regDstQ102H;
      fwd.regWrEnQ103H <= ctrlQ102H.regWrEn;
    end
  end

  always_ff @(posedge Clock) begin
    aluOutQ103H    <= aluOutQ102H;
    storeDataQ103H <= src2Q102H; // Forwarded rs2
    pcPlus4Q103H   <= pcPlus4Q102H;
  end

  // Decoder hands execute only listed operations for writing instructions
  assert property (@(posedge Clock) disable iff (rst)
    ctrlQ102H.regWrEn |-> ctrlQ102H.aluOp inside {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND});

endmodule

/* hdl/memWriteback.sv */
`timescale 1ns/1ps

module memWriteback
  import corePipePkg::*;
(
  input  logic  Clock,
  input  logic  rst,
  input  word_t aluOutQ103H,
  input  word_t storeDataQ103H,
  input  word_t pcPlus4Q103H,
  input  logic  dMemWrEnQ103H,
  input  logic  selDMemWbQ103H,
  input  logic  selRegWrPcQ103H,
  input  word_t dMemRdRsp,       // Registered by the memory, already Q104H
  output word_t dMemAddress,
  output word_t dMemWrData,
  output logic  dMemWrEn,
  fwdIf.wb      fwd
);

  word_t aluOutQ104H, pcPlus4Q104H;
  logic  selDMemWbQ104H, selRegWrPcQ104H;

  // Whole aligned words only
  assign dMemAddress = aluOutQ103H;
  assign dMemWrData  = storeDataQ103H;
  assign dMemWrEn    = dMemWrEnQ103H;

  always_ff @(posedge Clock) begin
    if (rst) begin
      selDMemWbQ104H   <= 1'b0;
      selRegWrPcQ104H  <= 1'b0;
      fwd.regDstQ104H  <= '0;
      fwd.regWrEnQ104H <= 1'b0;
    end else begin
      selDMemWbQ104H   <= selDMemWbQ103H;
      selRegWrPcQ104H  <= selRegWrPcQ103H;
      fwd.regDstQ104H  <= fwd.regDstQ103H;
      fwd.regWrEnQ104H <= fwd.regWrEnQ103H;
    end
  end

  always_ff @(posedge Clock) begin
    aluOutQ104H  <= aluOutQ103H;
    pcPlus4Q104H <= pcPlus4Q103H;
  end

  // Link beats load beats ALU
  assign fwd.regWrDataQ104H = selRegWrPcQ104H ? pcPlus4Q104H :
                              selDMemWbQ104H  ? dMemRdRsp    : aluOutQ104H;

endmodule

/* hdl/miniCore.sv */
`timescale 1ns/1ps

module miniCore
  import corePipePkg::*;
(
  input  logic  Clock,
  input  logic  rst,
  // Instruction memory
  output word_t PcQ100H,
  input  word_t PreInstructionQ101H,
  // Data memory
  output word_t DMemWrDataQ103H,
  output word_t DMemAddressQ103H,
  output logic  DMemWrEnQ103H,
  input  word_t DMemRdRspQ104H
);

  logic        pcEn, redirect, opcodeIsLoadQ102H;
  word_t       pcQ101H, pcPlus4Q101H, instrQ101H, immQ101H;
  word_t       rdData1, rdData2;
  word_t       aluOutQ102H, aluOutQ103H, storeDataQ103H, pcPlus4Q103H;
  regAddr_t    regDstQ102H;
  ctrlBundle_t ctrlQ101H;
  logic        storeEnQ103H, loadSelQ103H, linkSelQ103H;

  fwdIf fwd ();

  //////////////////// Fetch and decode
  pcFetch uPcFetch (
    .Clock, .rst, .pcEn, .redirect,
    .target      (aluOutQ102H),
    .pcQ100H     (PcQ100H),
    .pcQ101H, .pcPlus4Q101H
  );

  pipeControl uPipeControl (
    .Clock, .rst,
    .instrRaw    (PreInstructionQ101H),
    .redirect, .opcodeIsLoadQ102H, .regDstQ102H,
    .fwd         (fwd.ctrl),
    .pcEn, .instrQ101H, .immQ101H, .ctrlQ101H
  );

  regFile uRegFile (
    .Clock, .rst,
    .rdAddr1     (instrQ101H[19:15]),
    .rdAddr2     (instrQ101H[24:20]),
    .rdData1, .rdData2,
    .fwd         (fwd.wb)
  );

  //////////////////// Execute to write-back
  execUnit uExecUnit (
    .Clock, .rst, .pcQ101H, .pcPlus4Q101H, .instrQ101H, .immQ101H, .ctrlQ101H,
    .rdData1, .rdData2,
    .fwd         (fwd.exec),
    .redirect, .aluOutQ102H, .opcodeIsLoadQ102H, .regDstQ102H,
    .aluOutQ103H, .storeDataQ103H, .pcPlus4Q103H,
    .dMemWrEnQ103H   (storeEnQ103H),
    .selDMemWbQ103H  (loadSelQ103H),
    .selRegWrPcQ103H (linkSelQ103H)
  );

  memWriteback uMemWriteback (
    .Clock, .rst, .aluOutQ103H, .storeDataQ103H, .pcPlus4Q103H,
    .dMemWrEnQ103H   (storeEnQ103H),
    .selDMemWbQ103H  (loadSelQ103H),
    .selRegWrPcQ103H (linkSelQ103H),
    .dMemRdRsp   (DMemRdRspQ104H),
    .dMemAddress (DMemAddressQ103H),
    .dMemWrData  (DMemWrDataQ103H),
    .dMemWrEn    (DMemWrEnQ103H),
    .fwd         (fwd.wb)
  );

endmodule

/* verif/clkGen.sv */
`timescale 1ns/1ps

module clkGen #(
  parameter int HALF_PERIOD = 20 // ns, 40 ns period
) (
  output logic Clock
);

  initial begin
    Clock = 1'b0;
    forever #HALF_PERIOD Clock = ~Clock;
  end

endmodule

/* verif/coreTb.sv */
`timescale 1ns/1ps

module coreTb
  import rvIsaPkg::*;
  import corePipePkg::*;
();

  localparam int    RESET_CYCLES = 8;
  localparam word_t DONE_ADDR    = 32'h0000_03FC; // Last store of every program

  logic  Clock, rst;
  word_t PcQ100H, instrWord;
  word_t DMemWrDataQ103H, DMemAddressQ103H, dmemRdWord;
  logic  DMemWrEnQ103H;

  word_t imem [0:255];
  word_t dmem [0:255];
  word_t prog[$];                          // Program under construction
  word_t logAddr[$], logData[$];           // Every store seen, in order
  word_t expAddr[$], expData[$];
  bit    expIsPc[$];                       // Data is a link value
  logic  doneSeen;
  int    seed, errorCount, checkCount;
  int    budget = 16;                      // Watchdog cycles, grows per program

  clkGen uClkGen (.Clock);

  miniCore u_dut (
    .Clock, .rst, .PcQ100H,
    .PreInstructionQ101H (instrWord),
    .DMemWrDataQ103H, .DMemAddressQ103H, .DMemWrEnQ103H,
    .DMemRdRspQ104H      (dmemRdWord)
  );

  //////////////////// Memory models
  always @(posedge Clock) begin
    instrWord <= imem[PcQ100H[9:2]]; // Word shows up one cycle later
  end

  always @(posedge Clock) begin
    if (DMemWrEnQ103H) begin
      if (DMemAddressQ103H == DONE_ADDR) begin
        doneSeen <= 1'b1;
      end else begin
        dmem[DMemAddressQ103H[9:2]] <= DMemWrDataQ103H;
        logAddr.push_back(DMemAddressQ103H);
        logData.push_back(DMemWrDataQ103H);
      end
    end
    dmemRdWord <= dmem[DMemAddressQ103H[9:2]]; // Read data one cycle after address
  end

  //////////////////// Encoders
  function automatic word_t encR(logic [6:0] f7, regAddr_t rs2, regAddr_t rs1,
                                 logic [2:0] f3, regAddr_t rd);
    return {f7, rs2, rs1, f3, rd, R_OP};
  endfunction

  function automatic word_t encI(logic [11:0] imm, regAddr_t rs1, logic [2:0] f3,
                                 regAddr_t rd, opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t encS(logic [11:0] imm, regAddr_t rs2, regAddr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE}; // SW only
  endfunction

  function automatic word_t encB(logic [12:0] imm, regAddr_t rs2, regAddr_t rs1,
                                 logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
  endfunction

  function automatic word_t encJ(logic [20:0] imm, regAddr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
  endfunction

  //////////////////// Reference results
  function automatic word_t refAlu(logic [2:0] f3, logic alt, word_t a, word_t b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
      3'b000: begin
        if (alt) return a - b;
        return a + b;
      end
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) return sa >>> b[4:0]; // Sign fill
        return a >> b[4:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit branchTaken(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  //////////////////// Program helpers
  function automatic void emit(word_t w);
    prog.push_back(w);
  endfunction

  function automatic void loadConst(regAddr_t rd, word_t value);
    word_t rounded;
    rounded = value + 32'h800; // ADDI sign-extends its low part
    emit({rounded[31:12], rd, LUI});
    emit(encI(value[11:0], rd, 3'b000, rd, I_OP));
  endfunction

  function automatic void expectStore(word_t addr, word_t data, bit isPc);
    expAddr.push_back(addr);
    expData.push_back(data);
    expIsPc.push_back(isPc);
  endfunction

  function automatic void newProgram();
    prog.delete();
    expAddr.delete();
    expData.delete();
    expIsPc.delete();
  endfunction

  function automatic void finishProgram();
    emit(encS(DONE_ADDR[11:0], 0, 0));
    emit(encJ(21'd0, 0));              // Park on a self loop
    emit(NOP_INSTR);
    emit(NOP_INSTR);
  endfunction

  // Reset for RESET_CYCLES edges, program loaded while held
  task automatic startProgram();
    budget += prog.size() * 10 + 2 * RESET_CYCLES;
    @(posedge Clock);
    rst <= 1'b1;
    @(posedge Clock);
    @(negedge Clock);
    foreach (prog[i]) imem[i] = prog[i];
    logAddr.delete();
    logData.delete();
    doneSeen = 1'b0;
    repeat (RESET_CYCLES - 1) @(posedge Clock);
    rst <= 1'b0;
  endtask

  task automatic waitDone();
    while (!doneSeen) @(negedge Clock); // Watchdog bounds this
  endtask

  //////////////////// Compare tasks
  task automatic checkWord(string name, word_t got, word_t exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkPc(string name, word_t got, word_t exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compareStores(string testName);
    int i;
    checkCount++;
    if (logAddr.size() != expAddr.size()) begin
      errorCount++;
      $display("%s saw %0d stores where %0d were expected",
               testName, logAddr.size(), expAddr.size());
    end
    for (i = 0; i < expAddr.size(); i++) begin
      if (i >= logAddr.size()) begin
        $display("%s is missing the store to address %h", testName, expAddr[i]);
      end else begin
        checkWord("DMemAddressQ103H", logAddr[i], expAddr[i]);
        if (expIsPc[i]) checkPc("link in DMemWrDataQ103H", logData[i], expData[i]);
        else checkWord("DMemWrDataQ103H", logData[i], expData[i]);
      end
    end
  endtask

  //////////////////// Directed tests
  task automatic resetTest();
    int c;
    newProgram();
    emit(encS(12'h080, 0, 0));
    expectStore(32'h80, 32'h0, 1'b0);
    finishProgram();
    startProgram();
    @(negedge Clock);
    checkPc("PcQ100H", PcQ100H, RESET_PC);
    for (c = 0; c < 3; c++) begin
      if (c > 0) @(negedge Clock);
      checkBit("DMemWrEnQ103H", DMemWrEnQ103H, 1'b0); // Store not yet in Q103H
    end
    @(negedge Clock);
    checkBit("DMemWrEnQ103H", DMemWrEnQ103H, 1'b1);
    checkWord("DMemAddressQ103H", DMemAddressQ103H, 32'h80);
    waitDone();
    compareStores("reset test");
  endtask

  task automatic aluTest();
    word_t      a, b, addr;
    logic [11:0] imm12;
    logic [2:0] f3;
    logic       alt;
    int         i;
    newProgram();
    addr = 32'h100;
    repeat (2) begin
      a = $random(seed);
      b = $random(seed);
      loadConst(1, a);
      loadConst(2, b);
      for (i = 0; i < 10; i++) begin // Eight funct3 codes, then SUB and SRA
        f3  = (i < 8) ? i[2:0] : ((i == 8) ? 3'b000 : 3'b101);
        alt = (i >= 8);
        emit(encR(alt ? 7'b0100000 : 7'b0000000, 2, 1, f3, 3));
        emit(encS(addr[11:0], 3, 0));
        expectStore(addr, refAlu(f3, alt, a, b), 1'b0);
        addr += 4;
      end
      for (i = 0; i < 9; i++) begin // SRAI last
        f3    = (i < 8) ? i[2:0] : 3'b101;
        alt   = (i == 8);
        imm12 = $random(seed);
        if (f3 == 3'b001 || f3 == 3'b101) imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
        emit(encI(imm12, 1, f3, 3, I_OP));
        emit(encS(addr[11:0], 3, 0));
        expectStore(addr, refAlu(f3, alt, a, {{20{imm12[11]}}, imm12}), 1'b0);
        addr += 4;
      end
    end
    finishProgram();
    startProgram();
    waitDone();
    compareStores("ALU test");
  endtask

  task automatic fwdTest();
    word_t acc, inc, addr;
    int    d, k;
    newProgram();
    addr = 32'h180;
    acc  = $random(seed);
    inc  = $random(seed);
    loadConst(10, acc);
    loadConst(11, inc);
    for (d = 1; d <= 3; d++) begin
      for (k = 0; k < 2; k++) begin
        // Dependency on rs1 first, then on rs2
        if (k == 0) emit(encR(7'b0, 11, 10, 3'b000, 10));
        else emit(encR(7'b0, 10, 11, 3'b000, 10));
        acc += inc;
        repeat (d - 1) emit(NOP_INSTR);
      end
      emit(encS(addr[11:0], 10, 0));
      expectStore(addr, acc, 1'b0);
      addr += 4;
    end
    finishProgram();
    startProgram();
    waitDone();
    compareStores("forwarding test");
  endtask

  task automatic loadUseTest();
    word_t       v;
    logic [11:0] imm12;
    newProgram();
    v     = $random(seed);
    imm12 = $random(seed);
    loadConst(1, v);
    emit(encS(12'h040, 1, 0));
    expectStore(32'h40, v, 1'b0);
    emit(encI(12'h040, 0, 3'b010, 2, LOAD)); // Use through rs1
    emit(encI(imm12, 2, 3'b000, 3, I_OP));
    emit(encS(12'h044, 3, 0));
    expectStore(32'h44, v + {{20{imm12[11]}}, imm12}, 1'b0);
    emit(encI(12'h040, 0, 3'b010, 4, LOAD)); // Use through rs2
    emit(encR(7'b0, 4, 1, 3'b000, 5));
    emit(encS(12'h048, 5, 0));
    expectStore(32'h48, v + v, 1'b0);
    emit(encI(12'h040, 0, 3'b010, 6, LOAD)); // Store data straight from load
    emit(encS(12'h04C, 6, 0));
    expectStore(32'h4C, v, 1'b0);
    finishProgram();
    startProgram();
    waitDone();
    compareStores("load-use test");
  endtask

  task automatic branchTest();
    branch_t  kinds [6];
    word_t    valA, valB, opA, opB, slot, tgt, pcJ;
    regAddr_t rsA, rsB;
    int       k, p;
    newProgram();
    kinds = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
    valA  = 32'hFFFF_FFFB; // Negative signed, large unsigned
    valB  = 32'd3;
    loadConst(1, valA);
    loadConst(2, valB);
    loadConst(7, 32'h5A5A_0F0F);
    slot = 32'h200;
    tgt  = 32'h300;
    for (k = 0; k < 6; k++) begin
      for (p = 0; p < 3; p++) begin // Pairs (x1,x2), (x2,x1), (x1,x1)
        rsA = (p == 1) ? 5'd2 : 5'd1;
        rsB = (p == 0) ? 5'd2 : 5'd1;
        opA = (rsA == 5'd1) ? valA : valB;
        opB = (rsB == 5'd1) ? valA : valB;
        emit(encB(13'd12, rsB, rsA, kinds[k]));
        emit(encS(slot[11:0], 7, 0));
        emit(encS(slot[11:0] + 12'd4, 7, 0));
        if (!branchTaken(kinds[k], opA, opB)) begin
          expectStore(slot, 32'h5A5A_0F0F, 1'b0);
          expectStore(slot + 4, 32'h5A5A_0F0F, 1'b0);
        end
        emit(encS(tgt[11:0], 7, 0)); // Branch target
        expectStore(tgt, 32'h5A5A_0F0F, 1'b0);
        slot += 8;
        tgt  += 4;
      end
    end
    // JAL with link in x5
    pcJ = prog.size() * 4;
    emit(encJ(21'd12, 5));
    emit(encS(12'h290, 7, 0));
    emit(encS(12'h294, 7, 0));
    emit(encS(12'h348, 5, 0));
    expectStore(32'h348, pcJ + 4, 1'b1);
    // JALR through x8, set one instruction earlier
    pcJ = (prog.size() + 1) * 4;
    emit(encI(pcJ[11:0] + 12'd12, 0, 3'b000, 8, I_OP));
    emit(encI(12'd0, 8, 3'b000, 9, JALR));
    emit(encS(12'h298, 7, 0));
    emit(encS(12'h29C, 7, 0));
    emit(encS(12'h34C, 9, 0));
    expectStore(32'h34C, pcJ + 4, 1'b1);
    finishProgram();
    startProgram();
    waitDone();
    compareStores("branch and jump test");
  endtask

  //////////////////// Run control
  initial begin
    seed       = 39;
    errorCount = 0;
    checkCount = 0;
    doneSeen   = 1'b0;
    rst        = 1'b1;
    instrWord  = NOP_INSTR;
    dmemRdWord = '0;
    resetTest();
    aluTest();
    fwdTest();
    loadUseTest();
    branchTest();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Budget set by program lengths, 10 cycles per instruction
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= budget) begin
      @(posedge Clock);
      cycles++;
    end
    $display("Timeout after %0d cycles, a program never made its final store", cycles);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount + 1);
    $display("sim failed");
    $finish;
  end

endmodule

/* flist.f */
hdl/rvIsaPkg.sv
hdl/corePipePkg.sv
hdl/fwdIf.sv
hdl/pipeControl.sv
hdl/pcFetch.sv
hdl/regFile.sv
hdl/execUnit.sv
hdl/memWriteback.sv
hdl/miniCore.sv
verif/clkGen.sv
verif/coreTb.sv
